// ==== bench/ula_fx_checker.sv ====
// Assertions bound onto the ALU top, register outputs and reset only
// Result values themselves are compared by the monitor

`timescale 1ns/100ps
`default_nettype none

module ula_fx_checker import ula_fx_pkg::*; (
	input logic  clk,
	input logic  arst_n,
	input word_t out,
	input logic  is_zero
);

	// Flag always describes the held word
	zero_flag: assert property (@(posedge clk) disable iff (!arst_n) is_zero == (out == '0))
		else $error("is_zero does not match out");

	reset_clear: assert property (@(posedge clk) !arst_n |-> out == '0)
		else $error("out not cleared during reset");

	no_unknown: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(out))
		else $error("out has unknown bits after reset");

endmodule

bind ula_fx ula_fx_checker checker_inst (
	.clk     (clk),
	.arst_n  (arst_n),
	.out     (out),
	.is_zero (is_zero)
);

`default_nettype wire

// ==== bench/ula_fx_monitor.sv ====
// Reference model of the ALU and comparison of out and is_zero
// Compares on the falling clock edge, half a cycle after the register updates

`timescale 1ns/100ps
`default_nettype none

module ula_fx_monitor import ula_fx_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  op_e   op,
	input  word_t in1,
	input  word_t in2,
	input  word_t out,
	input  logic  is_zero,
	output int    checks,
	output int    errors
);

	logic  pend;    // Captured inputs belong to a live operation
	op_e   pend_op;
	word_t pend_a;
	word_t pend_b;

	function automatic word_t as_word(input logic c);
		return {31'd0, c};
	endfunction

	// ****************************************
	// Expected result from the operation rules
	// ****************************************

	function automatic word_t model(input op_e code, input word_t a, input word_t b);
		int         sa, sb;
		int         e1, e2, m1, m2;
		int         a1, a2, ec, d, sum;
		longint     prod;
		logic [8:0] ex9;
		sa = int'(a);
		sb = int'(b);
		e1 = int'($signed(a[30:23]));
		e2 = int'($signed(b[30:23]));
		m1 = int'(a[22:0]);
		m2 = int'(b[22:0]);
		d  = e1 - e2;
		a1 = (d < 0) ? m1 >> (-d) : m1; // Smaller exponent side loses bits
		a2 = (d < 0) ? m2 : m2 >> d;
		ec = (d < 0) ? e2 : e1;
		if (a[31])
			a1 = -a1;
		if (b[31])
			a2 = -a2;
		sum  = a1 + a2;
		ex9  = 9'(e1 + e2 + 23);
		prod = longint'(m1) * longint'(m2);
		case (code)
			OP_NOP:  return b;
			OP_LOAD: return a;
			OP_ADD:  return word_t'(sa + sb);
			OP_MLT:  return word_t'(sa * sb);
			OP_NEG:  return word_t'(-sb);
			OP_ABS:  return (sb < 0) ? word_t'(-sb) : b;
			OP_PST:  return (sb < 0) ? '0 : b;
			OP_SGN:  return ((sa < 0) == (sb < 0)) ? b : word_t'(-sb);
			OP_OR:   return a | b;
			OP_AND:  return a & b;
			OP_INV:  return ~b;
			OP_XOR:  return a ^ b;
			OP_LES:  return as_word(sa < sb);
			OP_GRE:  return as_word(sa > sb);
			OP_EQU:  return as_word(a == b);
			OP_LIN:  return as_word(b == '0);
			OP_LAN:  return as_word(a != '0 && b != '0);
			OP_LOR:  return as_word(a != '0 || b != '0);
			OP_SHL:  return (b > 32'd31) ? '0 : a << b[4:0];
			OP_SHR:  return (b > 32'd31) ? '0 : a >> b[4:0];
			OP_SRS:  return (b > 32'd31) ? {32{a[31]}} : word_t'(sa >>> b[4:0]);
			OP_FADD: return {sum < 0, 8'(ec + 1), 23'((sum < 0 ? -sum : sum) >> 1)};
			OP_FMLT: return {a[31] ^ b[31], ex9[7:0],
			                 (ex9[8:7] == 2'b10) ? 23'd0 : 23'(prod >> 23)};
			OP_FGRE: return as_word(a1 > a2);
			OP_FLES: return as_word(a1 < a2);
			OP_FNEG: return {~b[31], b[30:0]};
			OP_FABS: return {1'b0, b[30:0]};
			OP_FSGN: return {a[31], b[30:0]};
			OP_FPST: return b[31] ? 32'h4000_0000 : b;
			default: return '0;
		endcase
	endfunction

	task automatic compare(input word_t exp_out, input op_e code);
		logic exp_zero;
		exp_zero = (exp_out == '0);
		checks++;
		if (out !== exp_out) begin
			errors++;
			$display("** Error at %0t: out expected %h, actual %h (op %0d)",
			         $time, exp_out, out, code);
		end
		checks++;
		if (is_zero !== exp_zero) begin
			errors++;
			$display("** Error at %0t: is_zero expected %b, actual %b (op %0d)",
			         $time, exp_zero, is_zero, code);
		end
	endtask

	initial begin
		checks = 0;
		errors = 0;
		pend   = 1'b0;
	end

	// Inputs seen at a falling edge are the ones the next rising edge registers
	always @(negedge clk) begin
		if (!arst_n) begin
			compare('0, op);
			pend = 1'b0;
		end else begin
			if (pend)
				compare(model(pend_op, pend_a, pend_b), pend_op);
			pend = 1'b1;
		end
		pend_op = op;
		pend_a  = in1;
		pend_b  = in2;
	end

endmodule

`default_nettype wire

// ==== bench/ula_fx_tb.sv ====
// Testbench top for the ALU, seeded random stimulus, one operation per cycle
// The monitor does all comparing, this module reports per test and overall

`timescale 1ns/100ps
`default_nettype none

module ula_fx_tb import ula_fx_pkg::*; ();

	localparam int N_INT   = 300;
	localparam int N_LOGIC = 80;
	localparam int N_FLOAT = 300;
	localparam int N_B2B   = 200;
	localparam int CYCLES  = 8 + N_INT + N_LOGIC + N_FLOAT + 64 + N_B2B + 6 * 3;
	localparam int LIMIT_NS = CYCLES * 4 + 400; // Margin for reset and test gaps

	logic   clk;
	logic   arst_n;
	op_e    op;
	word_t  in1;
	word_t  in2;
	word_t  out;
	logic   is_zero;
	int     checks;
	int     errors;
	int     checks_before;
	int     errors_before;
	integer seed;
	int     i;
	int     e;
	op_e    code;
	word_t  a;
	word_t  b;

	op_e   int_ops[11]   = '{OP_NOP, OP_LOAD, OP_ADD, OP_MLT, OP_NEG, OP_ABS, OP_PST,
	                         OP_SGN, OP_SHL, OP_SHR, OP_SRS};
	op_e   logic_ops[10] = '{OP_OR, OP_AND, OP_INV, OP_XOR, OP_LES, OP_GRE, OP_EQU,
	                         OP_LIN, OP_LAN, OP_LOR};
	op_e   float_ops[8]  = '{OP_FNEG, OP_FADD, OP_FMLT, OP_FGRE, OP_FLES, OP_FSGN,
	                         OP_FABS, OP_FPST};
	word_t corners[4]    = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0};

	ula_fx ula_fx_inst (
		.clk     (clk),
		.arst_n  (arst_n),
		.op      (op),
		.in1     (in1),
		.in2     (in2),
		.out     (out),
		.is_zero (is_zero)
	);

	ula_fx_monitor monitor_inst (
		.clk     (clk),
		.arst_n  (arst_n),
		.op      (op),
		.in1     (in1),
		.in2     (in2),
		.out     (out),
		.is_zero (is_zero),
		.checks  (checks),
		.errors  (errors)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// ****************************************
	// Stimulus helpers
	// ****************************************

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % 32'(n));
	endfunction

	function automatic word_t rand_operand();
		logic [31:0] r;
		r = $random(seed);
		case (rand_below(4))
			0: return word_t'(rand_below(17) - 8); // Small values around zero
			1: return corners[rand_below(4)];
			default: return r;
		endcase
	endfunction

	function automatic word_t float_word(input int exp_val);
		return {rand_below(2) == 1, 8'(exp_val), 23'(rand_below(32'h80_0000))};
	endfunction

	task automatic issue(input op_e c, input word_t x, input word_t y);
		@(posedge clk);
		#0.5;
		op  = c;
		in1 = x;
		in2 = y;
	endtask

	// Last operation is checked one cycle after it was driven
	task automatic end_test(input string name);
		@(posedge clk);
		@(negedge clk);
		#0.5;
		$display("Test %s done: %0d checks, %0d errors", name,
		         checks - checks_before, errors - errors_before);
		checks_before = checks;
		errors_before = errors;
	endtask

	// ****************************************
	// Test sequence
	// ****************************************

	initial begin
		seed          = 82944;
		checks_before = 0;
		errors_before = 0;
		op            = OP_NOP;
		in1           = '0;
		in2           = '0;
		arst_n        = 1'b1;
		#1 arst_n     = 1'b0;   // Clean falling edge for the async clear
		repeat (8) @(posedge clk);
		#0.5 arst_n   = 1'b1;
		issue(OP_NOP, '0, '0);
		end_test("reset");

		for (i = 0; i < N_INT; i++) begin
			code = int_ops[rand_below(11)];
			a    = rand_operand();
			b    = rand_operand();
			if (code inside {OP_SHL, OP_SHR, OP_SRS})
				b = word_t'(rand_below(41)); // Reaches past the 32-bit saturation point
			issue(code, a, b);
		end
		end_test("integer");

		for (i = 0; i < N_LOGIC; i++) begin
			code = logic_ops[rand_below(10)];
			a    = rand_operand();
			b    = rand_operand();
			case (rand_below(4))
				0: a = '0;
				1: b = '0;
				2: begin
					a = '0;
					b = '0;
				end
				default: b = a;
			endcase
			issue(code, a, b);
		end
		end_test("logic");

		for (i = 0; i < N_FLOAT; i++) begin
			code = float_ops[rand_below(8)];
			e    = rand_below(195) - 97;
			if (code == OP_FMLT && rand_below(3) == 0)
				// Low exponent sums hit the flush pattern
				issue(code, float_word(rand_below(61) - 128), float_word(rand_below(61) - 128));
			else
				issue(code, float_word(e), float_word(e + rand_below(61) - 30));
		end
		end_test("float");

		for (i = 0; i < 64; i++) begin
			if (i inside {4, 5, 7, [24:28], 30, 33, 37, 39, 40, [42:63]})
				issue(op_e'(6'(i)), rand_operand(), rand_operand());
		end
		end_test("unused");

		for (i = 0; i < N_B2B; i++)
			issue(op_e'(6'(rand_below(64))), rand_operand(), rand_operand());
		end_test("b2b");

		$display("Summary: %0d checks passed, %0d errors", checks - errors, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	initial begin
		#(LIMIT_NS);
		$display("Timeout: tests did not finish within %0d ns", LIMIT_NS);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/ula_float.sv ====
// Float side of the ALU, purely combinational
// No overflow or infinity handling, exponents wrap
// Results are not normalised, opcodes outside the float set give zero

`timescale 1ns/100ps
`default_nettype none

`include "ula_fx_defs.svh"

module ula_float import ula_fx_pkg::*; (
	input  op_e   op,
	input  word_t in1,
	input  word_t in2,
	output word_t float_res
);

	// ****************************************
	// Add and compare on aligned operands
	// ****************************************

	expo_t  e_al;
	smant_t sm1;
	smant_t sm2;

	ula_float_align align_inst (
		.in1     (in1),
		.in2     (in2),
		.e_out   (e_al),
		.sm1_out (sm1),
		.sm2_out (sm2)
	);

	logic signed [`NBMANT+1:0] sum;   // One guard bit over the aligned width
	logic        [`NBMANT+1:0] mag;
	word_t                     fadd;
	expo_t                     e_add;

	assign sum   = {sm1[`NBMANT], sm1} + {sm2[`NBMANT], sm2};
	assign mag   = sum[`NBMANT+1] ? -sum : sum;
	assign e_add = e_al + expo_t'(1);  // Mantissa drops its LSB below
	assign fadd  = {sum[`NBMANT+1], e_add, mag[`NBMANT:1]};

	// ****************************************
	// Multiply
	// ****************************************

	expo_t                    e1, e2;
	mant_t                    m1, m2;
	logic     [2*`NBMANT-1:0] prod;
	logic signed [`NBEXPO:0]  e_mul;  // Wide enough to spot underflow
	logic                     unf;
	word_t                    fmlt;

	assign e1 = in1[`NUBITS-2:`NBMANT];
	assign e2 = in2[`NUBITS-2:`NBMANT];
	assign m1 = in1[`NBMANT-1:0];
	assign m2 = in2[`NBMANT-1:0];

	assign prod  = (2*`NBMANT)'(m1) * (2*`NBMANT)'(m2);
	assign e_mul = {e1[`NBEXPO-1], e1} + {e2[`NBEXPO-1], e2} + (`NBEXPO+1)'(`NBMANT);
	assign unf   = (e_mul[`NBEXPO:`NBEXPO-1] == 2'b10); // Flush small products
	assign fmlt  = {in1[`NUBITS-1] ^ in2[`NUBITS-1], e_mul[`NBEXPO-1:0],
	                unf ? mant_t'(0) : prod[2*`NBMANT-1:`NBMANT]};

	// ****************************************
	// Result select
	// ****************************************

	always_comb begin
		case (op)
			OP_FADD: float_res = fadd;
			OP_FMLT: float_res = fmlt;
			OP_FGRE: float_res = word_t'(sm1 > sm2);
			OP_FLES: float_res = word_t'(sm1 < sm2);

			// Sign field only
			OP_FNEG: float_res = {~in2[`NUBITS-1], in2[`NUBITS-2:0]};
			OP_FABS: float_res = {1'b0, in2[`NUBITS-2:0]};
			OP_FSGN: float_res = {in1[`NUBITS-1], in2[`NUBITS-2:0]};
			OP_FPST: float_res = in2[`NUBITS-1] ? {2'b01, {(`NUBITS-2){1'b0}}} : in2;

			default: float_res = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/ula_float_align.sv ====
// Brings two floats to a common exponent for add and compare
// The smaller operand loses the bits shifted out, no rounding
// A signed mantissa of -2^23 cannot occur since the field is 23 bits

`timescale 1ns/100ps
`default_nettype none

`include "ula_fx_defs.svh"

module ula_float_align import ula_fx_pkg::*; (
	input  word_t  in1,
	input  word_t  in2,
	output expo_t  e_out,
	output smant_t sm1_out,
	output smant_t sm2_out
);

	// Field split
	logic  s1, s2;
	expo_t e1, e2;
	mant_t m1, m2;

	assign s1 = in1[`NUBITS-1];
	assign s2 = in2[`NUBITS-1];
	assign e1 = in1[`NUBITS-2:`NBMANT];
	assign e2 = in2[`NUBITS-2:`NBMANT];
	assign m1 = in1[`NBMANT-1:0];
	assign m2 = in2[`NBMANT-1:0];

	logic signed [`NBEXPO:0] d;      // e1 - e2, one bit wider so it cannot wrap
	logic        [`NBEXPO:0] shift1;
	logic        [`NBEXPO:0] shift2;
	mant_t                   m1_sh;
	mant_t                   m2_sh;

	assign d = {e1[`NBEXPO-1], e1} - {e2[`NBEXPO-1], e2};

	// Only the operand with the smaller exponent is shifted
	assign shift1 = d[`NBEXPO] ? -d : '0;
	assign shift2 = d[`NBEXPO] ? '0 : d;
	assign e_out  = d[`NBEXPO] ? e2 : e1;

	assign m1_sh = m1 >> shift1;
	assign m2_sh = m2 >> shift2;

	// Two's complement mantissas
	assign sm1_out = s1 ? -smant_t'({1'b0, m1_sh}) : smant_t'({1'b0, m1_sh});
	assign sm2_out = s2 ? -smant_t'({1'b0, m2_sh}) : smant_t'({1'b0, m2_sh});

endmodule

`default_nettype wire

// ==== design/ula_fx.sv ====
// ALU top, one-cycle latency from op/in1/in2 to out and is_zero
// Inputs are plain levels sampled on every rising clk, no handshake
// Reset holds out at zero and is_zero high

`timescale 1ns/100ps
`default_nettype none

`include "ula_fx_defs.svh"

module ula_fx import ula_fx_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  op_e   op,
	input  word_t in1,
	input  word_t in2,
	output word_t out,
	output logic  is_zero
);

	// ****************************************
	// Result paths
	// ****************************************

	word_t int_res;   // Zero unless op is an integer code
	word_t float_res; // Zero unless op is a float code
	word_t res;

	ula_int int_inst (
		.op      (op),
		.in1     (in1),
		.in2     (in2),
		.int_res (int_res)
	);

	ula_float float_inst (
		.op        (op),
		.in1       (in1),
		.in2       (in2),
		.float_res (float_res)
	);

	// Each opcode is owned by exactly one path, so OR is the merge
	assign res = int_res | float_res;

	// ****************************************
	// Accumulator register
	// ****************************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out     <= '0;
			is_zero <= 1'b1;   // Consistent with the cleared word
		end else begin
			out     <= res;
			is_zero <= (res == '0);
		end
	end

endmodule

`default_nettype wire

// ==== design/ula_fx_defs.svh ====
// Width defines shared by the ALU and its bench
// The float layout assumes NUBITS == 1 + NBEXPO + NBMANT
// Changing a width also changes the opcode-free float constants

`ifndef ULA_FX_DEFS_SVH
`define ULA_FX_DEFS_SVH

// ****************************************
// Data path widths
// ****************************************

`define NUBITS 32 // Operand and result word

// Float fields, packed as {sign, exponent, mantissa}
`define NBMANT 23 // Unnormalised mantissa
`define NBEXPO 8  // Two's-complement exponent

// ****************************************
// Control
// ****************************************

`define OPBITS 6  // Opcode, 64 codes of which the ALU uses 29

`endif

// ==== design/ula_fx_pkg.sv ====
// Types of the ALU data path and its opcode set
// Codes not listed in op_e are legal on the bus and yield a zero result

`default_nettype none

`include "ula_fx_defs.svh"

package ula_fx_pkg;

	typedef logic        [`NUBITS-1:0] word_t;  // Operand or result word
	typedef logic        [`NBMANT-1:0] mant_t;  // Raw mantissa field
	typedef logic signed [`NBEXPO-1:0] expo_t;  // Exponent field
	typedef logic signed [`NBMANT:0]   smant_t; // Aligned mantissa with sign applied

	// Processor opcode numbering, gaps are dropped operations
	typedef enum logic [`OPBITS-1:0] {
		OP_NOP  = 0,  // in2
		OP_LOAD = 1,  // in1
		OP_ADD  = 2,
		OP_MLT  = 3,
		OP_NEG  = 6,
		OP_ABS  = 8,
		OP_PST  = 9,  // Clamp negatives to zero
		OP_SGN  = 10, // Sign of in1 applied to in2
		OP_OR   = 11,
		OP_AND  = 12,
		OP_INV  = 13,
		OP_XOR  = 14,
		OP_LES  = 15,
		OP_GRE  = 16,
		OP_EQU  = 17,
		OP_LIN  = 18, // Logical not
		OP_LAN  = 19, // Logical and
		OP_LOR  = 20, // Logical or
		OP_SHL  = 21,
		OP_SHR  = 22,
		OP_SRS  = 23, // Arithmetic right shift
		OP_FNEG = 29,
		OP_FADD = 31,
		OP_FMLT = 32,
		OP_FGRE = 34,
		OP_FLES = 35,
		OP_FSGN = 36,
		OP_FABS = 38,
		OP_FPST = 41
	} op_e;

endpackage

`default_nettype wire

// ==== design/ula_int.sv ====
// Integer side of the ALU, purely combinational
// Operands are signed, only the low word of ADD and MLT is kept
// Opcodes outside the integer set give zero so the top can OR results

`timescale 1ns/100ps
`default_nettype none

`include "ula_fx_defs.svh"

module ula_int import ula_fx_pkg::*; (
	input  op_e   op,
	input  word_t in1,
	input  word_t in2,
	output word_t int_res
);

	word_t neg2;   // -in2, shared by NEG, ABS and SGN
	logic  sign1;
	logic  sign2;
	logic  zero1;
	logic  zero2;

	assign neg2  = -in2;
	assign sign1 = in1[`NUBITS-1];
	assign sign2 = in2[`NUBITS-1];
	assign zero1 = (in1 == '0);
	assign zero2 = (in2 == '0);

	// ****************************************
	// Result select
	// ****************************************

	always_comb begin
		case (op)
			// Pass-through
			OP_NOP:  int_res = in2;
			OP_LOAD: int_res = in1;

			// Arithmetic
			OP_ADD:  int_res = in1 + in2;
			OP_MLT:  int_res = in1 * in2; // Low 32 bits, same for signed
			OP_NEG:  int_res = neg2;
			OP_ABS:  int_res = sign2 ? neg2 : in2;
			OP_PST:  int_res = sign2 ? '0 : in2;
			OP_SGN:  int_res = (sign1 == sign2) ? in2 : neg2;

			// Bitwise logic
			OP_OR:   int_res = in1 | in2;
			OP_AND:  int_res = in1 & in2;
			OP_INV:  int_res = ~in2;
			OP_XOR:  int_res = in1 ^ in2;

			// Signed compares, result is word 0 or 1
			OP_LES:  int_res = word_t'($signed(in1) < $signed(in2));
			OP_GRE:  int_res = word_t'($signed(in1) > $signed(in2));
			OP_EQU:  int_res = word_t'(in1 == in2);

			// One-bit logic on whole words
			OP_LIN:  int_res = word_t'(zero2);
			OP_LAN:  int_res = word_t'(!zero1 && !zero2);
			OP_LOR:  int_res = word_t'(!zero1 || !zero2);

			// Shift count is the full unsigned in2
			// Counts of 32 and up empty the word, or fill it with the sign for SRS
			OP_SHL:  int_res = in1 << in2;
			OP_SHR:  int_res = in1 >> in2;
			OP_SRS:  int_res = word_t'($signed(in1) >>> in2);

			default: int_res = '0; // Float codes and unused codes
		endcase
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the ALU testbench with Verilator and runs it
# Exit status is 0 only when the run prints the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module ula_fx_tb -f ula_fx.f -o ula_fx_sim
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

# A raised error limit lets the bench reach its summary after assertion errors
output=$(./obj_dir/ula_fx_sim +verilator+error+limit+100)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== ula_fx.f ====
+incdir+design
design/ula_fx_pkg.sv
design/ula_int.sv
design/ula_float_align.sv
design/ula_float.sv
design/ula_fx.sv
bench/ula_fx_checker.sv
bench/ula_fx_monitor.sv
bench/ula_fx_tb.sv
